//--- cpu.f
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
register_bank.sv
execute_stage.sv
data_ram.sv
memory_stage.sv
cpu.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu -f cpu.f -o tb_cpu

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/tb_cpu

//--- cpu_golden.txt
# I lines hold one instruction word in hex, in ROM order from address 0
# W lines hold rd and the written data in hex, in retirement order
I 00500093  # addi x1, x0, 5
W 01 00000005
I ffd00113  # addi x2, x0, -3
W 02 fffffffd
I 002081b3  # add  x3, x1, x2
W 03 00000002
I 40208233  # sub  x4, x1, x2
W 04 00000008
I 0041e2b3  # or   x5, x3, x4
W 05 0000000a
I 0012c333  # xor  x6, x5, x1
W 06 0000000f
I 005373b3  # and  x7, x6, x5
W 07 0000000a
I 00112433  # slt  x8, x2, x1
W 08 00000001
I fff0a493  # slti x9, x1, -1
W 09 00000000
I 0f034513  # xori x10, x6, 0xf0
W 0a 000000ff
I 10056593  # ori  x11, x10, 0x100
W 0b 000001ff
I 0f35f613  # andi x12, x11, 0xf3
W 0c 000000f3
I 123456b7  # lui  x13, 0x12345
W 0d 12345000
I 67868693  # addi x13, x13, 0x678
W 0d 12345678
I 00d02823  # sw   x13, 16(x0)
I 01002703  # lw   x14, 16(x0)
W 0e 12345678
I 001707b3  # add  x15, x14, x1
W 0f 1234567d
I 01002803  # lw   x16, 16(x0)
W 10 12345678
I 410088b3  # sub  x17, x1, x16
W 11 edcba98d
I 00708013  # addi x0, x1, 7
I 00100933  # add  x18, x0, x1
W 12 00000005
I 00208463  # beq  x1, x2, +8 not taken
I 00100993  # addi x19, x0, 1
W 13 00000001
I 01209463  # bne  x1, x18, +8 not taken
I 00200a13  # addi x20, x0, 2
W 14 00000002
I 01208663  # beq  x1, x18, +12 taken
I 7ff00a93  # addi x21, x0, 0x7ff skipped
I 7ff00b13  # addi x22, x0, 0x7ff skipped
I 00209663  # bne  x1, x2, +12 taken
I 55500a93  # addi x21, x0, 0x555 skipped
I 55500b13  # addi x22, x0, 0x555 skipped
I 00c00bef  # jal  x23, +12
W 17 00000080
I 33300c13  # addi x24, x0, 0x333 skipped
I 44400c13  # addi x24, x0, 0x444 skipped
I 013b8cb3  # add  x25, x23, x19
W 19 00000081
I 00012d13  # slti x26, x2, 0
W 1a 00000001
I 013d0463  # beq  x26, x19, +8 taken
I 22200d93  # addi x27, x0, 0x222 skipped
I 012c8d93  # addi x27, x25, 0x12
W 1b 00000093
I 0000006f  # jal  x0, 0 self-loop

//--- tb_cpu.sv
`include "riscv_consts.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam cpu_pkg::word_t NOP = 32'h0000_0013;    // addi x0, x0, 0
    localparam int ROM_WORDS = 64;

    logic                 clock = 1'b0;
    logic                 arst_n;
    logic                 enable;
    cpu_pkg::word_t       rom_address;
    cpu_pkg::word_t       rom_data;
    logic [`LED_BITS-1:0] led;
    logic                 rf_write_enable;
    cpu_pkg::reg_addr_t   rf_write_addr;
    cpu_pkg::word_t       rf_write_data;

    cpu_pkg::word_t     rom [ROM_WORDS];
    logic [29:0]        rom_count = '0;
    cpu_pkg::reg_addr_t exp_rd [$];
    cpu_pkg::word_t     exp_data [$];
    cpu_pkg::word_t     last_data = '0;
    int                 seed = 26;
    int                 cycles = 0;
    int                 limit = 0;
    logic               live = 1'b0;
    logic               en_at_edge = 1'b0;    // Enable seen by the last rising edge

    cpu UUT (
        .clock, .arst_n, .enable, .rom_address, .rom_data, .led,
        .rf_write_enable, .rf_write_addr, .rf_write_data
    );

    always #4 clock = ~clock;

    // Instruction ROM answers in the same cycle
    always_comb begin
        if (rom_address[31:2] < rom_count) begin
            rom_data = rom[rom_address[7:2]];
        end else begin
            rom_data = NOP;
        end
    end

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            stop_with_failure("Mismatch against the golden trace");
        end
    endtask

    // I lines fill the ROM, W lines queue the expected writes
    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("cpu_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open cpu_golden.txt for reading");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1) begin
                tag = line.getc(0);
                a = '0;
                b = '0;
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                if (tag == "I") begin
                    rom[rom_count[5:0]] = a;
                    rom_count = rom_count + 30'd1;
                end else if (tag == "W") begin
                    if (n != 2) begin
                        stop_with_failure("Malformed write line in cpu_golden.txt");
                    end
                    exp_rd.push_back(a[4:0]);
                    exp_data.push_back(b);
                    last_data = b;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin : stimulus
        int gap;
        int len;
        arst_n = 1'b0;
        enable = 1'b1;
        repeat (16) @(negedge clock);
        arst_n = 1'b1;
        // Three freeze windows at random points of the program
        for (int w = 0; w < 3; w++) begin
            gap = 4 + $unsigned($random(seed)) % 12;
            len = 1 + $unsigned($random(seed)) % 8;
            repeat (gap) @(negedge clock);
            enable = 1'b0;
            repeat (len) @(negedge clock);
            enable = 1'b1;
        end
    end

    always @(posedge clock) begin
        live       = arst_n;
        en_at_edge = enable;
        if (live) begin
            cycles = cycles + 1;
            if (cycles > limit) begin
                stop_with_failure($sformatf(
                    "Timeout after %0d cycles with %0d expected writes still missing",
                    limit, exp_rd.size()));
            end
        end
    end

    initial begin : monitor
        cpu_pkg::reg_addr_t rd_want;
        cpu_pkg::word_t     data_want;
        logic               we_prev;
        cpu_pkg::reg_addr_t addr_prev;
        cpu_pkg::word_t     data_prev;
        cpu_pkg::word_t     pc_prev;
        load_golden();
        limit = 8 * exp_rd.size() + 200;
        forever begin
            @(negedge clock);
            if (live && !en_at_edge) begin
                // Frozen core, trace and PC must not move
                check_value(32'(rf_write_enable), 32'(we_prev), "write enable while frozen");
                check_value(32'(rf_write_addr), 32'(addr_prev), "write address while frozen");
                check_value(rf_write_data, data_prev, "write data while frozen");
                check_value(rom_address, pc_prev, "PC while frozen");
            end else if (live && rf_write_enable) begin
                if (exp_rd.size() == 0) begin
                    stop_with_failure($sformatf(
                        "Unexpected register write to x%0d after the trace was complete",
                        rf_write_addr));
                end else begin
                    rd_want   = exp_rd.pop_front();
                    data_want = exp_data.pop_front();
                    check_value(32'(rf_write_addr), 32'(rd_want), "write address");
                    check_value(rf_write_data, data_want,
                                $sformatf("data written to x%0d", rd_want));
                end
            end
            we_prev   = rf_write_enable;
            addr_prev = rf_write_addr;
            data_prev = rf_write_data;
            pc_prev   = rom_address;
        end
    end

    initial begin : finish_run
        @(posedge arst_n);
        while (exp_rd.size() != 0) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock);    // Room for any stray write
        check_value(32'(led), 32'(last_data[`LED_BITS-1:0]), "led after the last write");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- cpu.sv
`include "riscv_consts.svh"

module cpu (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 enable,
    output cpu_pkg::word_t       rom_address,
    input  cpu_pkg::word_t       rom_data,
    output logic [`LED_BITS-1:0] led,
    output logic                 rf_write_enable,
    output cpu_pkg::reg_addr_t   rf_write_addr,
    output cpu_pkg::word_t       rf_write_data
);
    // Fetch to decode
    cpu_pkg::word_t     if_pc, if_instr;
    logic               if_valid, stall;

    // Register bank reads
    cpu_pkg::reg_addr_t rs1_addr, rs2_addr;
    cpu_pkg::word_t     rs1_data, rs2_data;

    // ID/EX
    logic               id_valid, id_alu_src_imm, id_mem_read, id_mem_write, id_reg_write;
    cpu_pkg::word_t     id_pc, id_rs1_data, id_rs2_data, id_imm;
    cpu_pkg::reg_addr_t id_rs1_addr, id_rs2_addr, id_rd;
    cpu_pkg::alu_op_t   id_alu_op;
    cpu_pkg::branch_t   id_branch;

    // EX/MEM and redirect
    logic               redirect, ex_valid, ex_mem_read, ex_mem_write, ex_reg_write;
    cpu_pkg::word_t     redirect_pc, ex_result, ex_store_data, ram_rdata;
    cpu_pkg::reg_addr_t ex_rd;

    fetch_stage fetch (
        .clock, .arst_n, .enable, .stall, .redirect, .redirect_pc,
        .rom_address, .rom_data, .if_pc, .if_instr, .if_valid
    );

    decode_stage decode (
        .clock, .arst_n, .enable, .if_pc, .if_instr, .if_valid, .redirect,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_rd, .ex_reg_write, .ex_mem_read, .stall,
        .id_valid, .id_pc, .id_rs1_addr, .id_rs2_addr, .id_rs1_data, .id_rs2_data,
        .id_imm, .id_alu_op, .id_alu_src_imm, .id_mem_read, .id_mem_write,
        .id_reg_write, .id_rd, .id_branch
    );

    register_bank regs (
        .clock, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rf_write_enable, .rf_write_addr, .rf_write_data
    );

    execute_stage execute (
        .clock, .arst_n, .enable,
        .id_valid, .id_pc, .id_rs1_addr, .id_rs2_addr, .id_rs1_data, .id_rs2_data,
        .id_imm, .id_alu_op, .id_alu_src_imm, .id_mem_read, .id_mem_write,
        .id_reg_write, .id_rd, .id_branch,
        .rf_write_enable, .rf_write_addr, .rf_write_data,    // MEM/WB forwarding
        .redirect, .redirect_pc,
        .ex_valid, .ex_result, .ex_store_data, .ex_mem_read, .ex_mem_write,
        .ex_reg_write, .ex_rd
    );

    data_ram dmem (
        .clock,
        .enable,
        .ram_addr  (ex_result),
        .ram_wdata (ex_store_data),
        .ram_write (ex_mem_write && ex_valid),
        .ram_rdata (ram_rdata)
    );

    memory_stage memory (
        .clock, .arst_n, .enable, .ex_valid, .ex_result, .ex_mem_read,
        .ex_reg_write, .ex_rd, .ram_rdata,
        .rf_write_enable, .rf_write_addr, .rf_write_data, .led
    );

endmodule

//--- memory_stage.sv
`include "riscv_consts.svh"

module memory_stage (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 enable,
    input  logic                 ex_valid,
    input  cpu_pkg::word_t       ex_result,
    input  logic                 ex_mem_read,
    input  logic                 ex_reg_write,
    input  cpu_pkg::reg_addr_t   ex_rd,
    input  cpu_pkg::word_t       ram_rdata,
    output logic                 rf_write_enable,
    output cpu_pkg::reg_addr_t   rf_write_addr,
    output cpu_pkg::word_t       rf_write_data,
    output logic [`LED_BITS-1:0] led
);
    logic           wb_mem_read;
    cpu_pkg::word_t wb_result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rf_write_enable <= 1'b0;
            wb_mem_read     <= 1'b0;
        end else if (enable) begin
            // x0 targets retire silently
            rf_write_enable <= ex_valid && ex_reg_write && ex_rd != 5'd0;
            wb_mem_read     <= ex_mem_read;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            rf_write_addr <= ex_rd;
            wb_result     <= ex_result;
        end
    end

    // Writeback select, RAM data lines up with MEM/WB
    assign rf_write_data = wb_mem_read ? ram_rdata : wb_result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (enable && rf_write_enable) begin
            led <= rf_write_data[`LED_BITS-1:0];
        end
    end

endmodule

//--- data_ram.sv
`include "riscv_consts.svh"

module data_ram (
    input  logic           clock,
    input  logic           enable,
    input  cpu_pkg::word_t ram_addr,
    input  cpu_pkg::word_t ram_wdata,
    input  logic           ram_write,
    output cpu_pkg::word_t ram_rdata
);
    cpu_pkg::word_t      mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] index;

    assign index = ram_addr[`DMEM_AW+1:2];    // Word address, byte offset dropped

    always_ff @(posedge clock) begin
        if (enable) begin
            if (ram_write) begin
                mem[index] <= ram_wdata;
            end
            ram_rdata <= mem[index];    // Ready one cycle later
        end
    end

endmodule

//--- execute_stage.sv
module execute_stage (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               enable,
    input  logic               id_valid,
    input  cpu_pkg::word_t     id_pc,
    input  cpu_pkg::reg_addr_t id_rs1_addr,
    input  cpu_pkg::reg_addr_t id_rs2_addr,
    input  cpu_pkg::word_t     id_rs1_data,
    input  cpu_pkg::word_t     id_rs2_data,
    input  cpu_pkg::word_t     id_imm,
    input  cpu_pkg::alu_op_t   id_alu_op,
    input  logic               id_alu_src_imm,
    input  logic               id_mem_read,
    input  logic               id_mem_write,
    input  logic               id_reg_write,
    input  cpu_pkg::reg_addr_t id_rd,
    input  cpu_pkg::branch_t   id_branch,
    input  logic               rf_write_enable,
    input  cpu_pkg::reg_addr_t rf_write_addr,
    input  cpu_pkg::word_t     rf_write_data,
    output logic               redirect,
    output cpu_pkg::word_t     redirect_pc,
    output logic               ex_valid,
    output cpu_pkg::word_t     ex_result,
    output cpu_pkg::word_t     ex_store_data,
    output logic               ex_mem_read,
    output logic               ex_mem_write,
    output logic               ex_reg_write,
    output cpu_pkg::reg_addr_t ex_rd
);
    cpu_pkg::word_t op_a, op_b, alu_b, alu_out;
    logic           taken;

    // EX/MEM wins over MEM/WB, the youngest value
    function automatic cpu_pkg::word_t forward(cpu_pkg::reg_addr_t addr,
                                               cpu_pkg::word_t value);
        if (ex_reg_write && ex_rd != 5'd0 && ex_rd == addr) begin
            return ex_result;
        end
        if (rf_write_enable && addr != 5'd0 && rf_write_addr == addr) begin
            return rf_write_data;
        end
        return value;
    endfunction

    always_comb begin
        op_a  = forward(id_rs1_addr, id_rs1_data);
        op_b  = forward(id_rs2_addr, id_rs2_data);
        alu_b = id_alu_src_imm ? id_imm : op_b;
        case (id_alu_op)
            cpu_pkg::ALU_SUB:    alu_out = op_a - alu_b;
            cpu_pkg::ALU_AND:    alu_out = op_a & alu_b;
            cpu_pkg::ALU_OR:     alu_out = op_a | alu_b;
            cpu_pkg::ALU_XOR:    alu_out = op_a ^ alu_b;
            cpu_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            cpu_pkg::ALU_PASS_B: alu_out = alu_b;
            default:             alu_out = op_a + alu_b;
        endcase
        case (id_branch)
            cpu_pkg::BR_EQ:  taken = (op_a == op_b);
            cpu_pkg::BR_NE:  taken = (op_a != op_b);
            cpu_pkg::BR_JAL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign redirect    = id_valid && taken;
    assign redirect_pc = id_pc + id_imm;    // B and J targets are pc-relative

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (enable) begin
            ex_valid     <= id_valid;
            ex_mem_read  <= id_valid && id_mem_read;
            ex_mem_write <= id_valid && id_mem_write;
            ex_reg_write <= id_valid && id_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            ex_result     <= (id_branch == cpu_pkg::BR_JAL) ? id_pc + 32'd4 : alu_out;
            ex_store_data <= op_b;
            ex_rd         <= id_rd;
        end
    end

    a_rw_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
        !(ex_mem_read && ex_mem_write));

endmodule

//--- register_bank.sv
module register_bank (
    input  logic               clock,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,
    input  logic               rf_write_enable,
    input  cpu_pkg::reg_addr_t rf_write_addr,
    input  cpu_pkg::word_t     rf_write_data
);
    cpu_pkg::word_t regs [32];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write_enable) begin
            regs[rf_write_addr] <= rf_write_data;
        end
    end

    // Write-first bypass, x0 forced to zero
    always_comb begin
        rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
        rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
        if (rf_write_enable && rf_write_addr == rs1_addr && rs1_addr != 5'd0) begin
            rs1_data = rf_write_data;
        end
        if (rf_write_enable && rf_write_addr == rs2_addr && rs2_addr != 5'd0) begin
            rs2_data = rf_write_data;
        end
    end

    a_no_x0_write: assert property (@(posedge clock) disable iff (!arst_n)
        rf_write_enable |-> rf_write_addr != 5'd0);

endmodule

//--- decode_stage.sv
`include "riscv_consts.svh"

module decode_stage (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 enable,
    input  cpu_pkg::word_t       if_pc,
    input  cpu_pkg::word_t       if_instr,
    input  logic                 if_valid,
    input  logic                 redirect,
    output cpu_pkg::reg_addr_t   rs1_addr,
    output cpu_pkg::reg_addr_t   rs2_addr,
    input  cpu_pkg::word_t       rs1_data,
    input  cpu_pkg::word_t       rs2_data,
    input  cpu_pkg::reg_addr_t   ex_rd,
    input  logic                 ex_reg_write,
    input  logic                 ex_mem_read,
    output logic                 stall,
    output logic                 id_valid,
    output cpu_pkg::word_t       id_pc,
    output cpu_pkg::reg_addr_t   id_rs1_addr,
    output cpu_pkg::reg_addr_t   id_rs2_addr,
    output cpu_pkg::word_t       id_rs1_data,
    output cpu_pkg::word_t       id_rs2_data,
    output cpu_pkg::word_t       id_imm,
    output cpu_pkg::alu_op_t     id_alu_op,
    output logic                 id_alu_src_imm,
    output logic                 id_mem_read,
    output logic                 id_mem_write,
    output logic                 id_reg_write,
    output cpu_pkg::reg_addr_t   id_rd,
    output cpu_pkg::branch_t     id_branch
);
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             f3_ok;
    cpu_pkg::alu_op_t f3_op;
    logic             use_rs1, use_rs2;
    cpu_pkg::word_t   imm;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::branch_t branch;
    logic             alu_src_imm, mem_read, mem_write, reg_write;

    assign opcode = if_instr[6:0];
    assign funct3 = if_instr[14:12];

    // ALU ops shared by register and immediate forms
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            `F3_ADD: f3_op = cpu_pkg::ALU_ADD;
            `F3_SLT: f3_op = cpu_pkg::ALU_SLT;
            `F3_XOR: f3_op = cpu_pkg::ALU_XOR;
            `F3_OR:  f3_op = cpu_pkg::ALU_OR;
            `F3_AND: f3_op = cpu_pkg::ALU_AND;
            default: begin
                f3_op = cpu_pkg::ALU_ADD;
                f3_ok = 1'b0;    // Shifts and SLTU are outside the subset
            end
        endcase
    end

    always_comb begin
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        imm         = '0;
        alu_op      = cpu_pkg::ALU_ADD;
        branch      = cpu_pkg::BR_NONE;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                use_rs1   = f3_ok;
                use_rs2   = f3_ok;
                reg_write = f3_ok;
                alu_op    = (funct3 == `F3_ADD && if_instr[31:25] == `F7_SUB) ?
                            cpu_pkg::ALU_SUB : f3_op;
            end
            `OP_ITYPE: begin
                use_rs1     = f3_ok;
                reg_write   = f3_ok;
                alu_src_imm = 1'b1;
                alu_op      = f3_op;
                imm         = {{20{if_instr[31]}}, if_instr[31:20]};
            end
            `OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = cpu_pkg::ALU_PASS_B;
                imm         = {if_instr[31:12], 12'b0};
            end
            `OP_LOAD: if (funct3 == `F3_LW) begin
                use_rs1     = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = {{20{if_instr[31]}}, if_instr[31:20]};
            end
            `OP_STORE: if (funct3 == `F3_SW) begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;    // Store data
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            end
            `OP_BRANCH: if (funct3 == `F3_BEQ || funct3 == `F3_BNE) begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                branch  = (funct3 == `F3_BEQ) ? cpu_pkg::BR_EQ : cpu_pkg::BR_NE;
                imm     = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                           if_instr[30:25], if_instr[11:8], 1'b0};
            end
            `OP_JAL: begin
                reg_write = 1'b1;
                branch    = cpu_pkg::BR_JAL;
                imm       = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                             if_instr[20], if_instr[30:21], 1'b0};
            end
            default: ;    // NOP
        endcase
    end

    // Unused sources read as x0 so they never match a hazard
    assign rs1_addr = use_rs1 ? if_instr[19:15] : 5'd0;
    assign rs2_addr = use_rs2 ? if_instr[24:20] : 5'd0;

    // Load in ID/EX feeding the instruction in decode
    assign stall = if_valid && id_valid && id_mem_read && id_rd != 5'd0 &&
                   (id_rd == rs1_addr || id_rd == rs2_addr);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_valid       <= 1'b0;
            id_alu_op      <= cpu_pkg::ALU_ADD;
            id_alu_src_imm <= 1'b0;
            id_mem_read    <= 1'b0;
            id_mem_write   <= 1'b0;
            id_reg_write   <= 1'b0;
            id_branch      <= cpu_pkg::BR_NONE;
        end else if (enable) begin
            id_valid       <= if_valid && !stall && !redirect;    // Bubble otherwise
            id_alu_op      <= alu_op;
            id_alu_src_imm <= alu_src_imm;
            id_mem_read    <= mem_read;
            id_mem_write   <= mem_write;
            id_reg_write   <= reg_write;
            id_branch      <= branch;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            id_pc       <= if_pc;
            id_rs1_addr <= rs1_addr;
            id_rs2_addr <= rs2_addr;
            id_rs1_data <= rs1_data;
            id_rs2_data <= rs2_data;
            id_imm      <= imm;
            id_rd       <= if_instr[11:7];
        end
    end

    a_stall_vs_flush: assert property (@(posedge clock) disable iff (!arst_n)
        !(stall && redirect));

    // Load result is never needed straight out of EX/MEM
    a_load_use_gap: assert property (@(posedge clock) disable iff (!arst_n)
        (ex_mem_read && ex_reg_write && ex_rd != 5'd0 && id_valid) |->
        (id_rs1_addr != ex_rd && id_rs2_addr != ex_rd));

endmodule

//--- fetch_stage.sv
`include "riscv_consts.svh"

module fetch_stage (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           enable,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    output cpu_pkg::word_t rom_address,
    input  cpu_pkg::word_t rom_data,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr,
    output logic           if_valid
);
    cpu_pkg::word_t pc;

    assign rom_address = pc;    // ROM answers in the same cycle

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RESET_PC;
            if_valid <= 1'b0;
        end else if (enable) begin
            if (redirect) begin
                pc       <= redirect_pc;
                if_valid <= 1'b0;    // Wrong-path fetch dropped
            end else if (!stall) begin
                pc       <= pc + 32'd4;
                if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable && !stall) begin
            if_pc    <= pc;
            if_instr <= rom_data;
        end
    end

    a_pc_aligned: assert property (@(posedge clock) disable iff (!arst_n)
        pc[1:0] == 2'b00);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B    // LUI
    } alu_op_t;

    // Control transfer kind, resolved in execute
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } branch_t;

endpackage

//--- riscv_consts.svh
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// Major opcodes of the supported subset
`define OP_RTYPE   7'b0110011
`define OP_ITYPE   7'b0010011
`define OP_LUI     7'b0110111
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_BRANCH  7'b1100011
`define OP_JAL     7'b1101111

`define F3_ADD     3'b000
`define F3_SLT     3'b010
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_LW      3'b010
`define F3_SW      3'b010
`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F7_SUB     7'b0100000

`define RESET_PC   32'h0000_0000
`define DMEM_WORDS 256
`define DMEM_AW    8    // log2 of DMEM_WORDS
`define LED_BITS   6

`endif
